//--- regfile.f
mem_pkg.sv
exec_pkg.sv
mem_reset_sequencer.sv
mem_distributed_ram.sv
mem_combinational.sv
regfile_exec.sv
regfile_top.sv
regfile_properties.sv
regfile_tb.sv

//--- Bender.yml
package:
  name: regfile

sources:
  - mem_pkg.sv
  - exec_pkg.sv
  - mem_reset_sequencer.sv
  - mem_distributed_ram.sv
  - mem_combinational.sv
  - regfile_exec.sv
  - regfile_top.sv
  - target: test
    files:
      - regfile_properties.sv
      - regfile_tb.sv

//--- regfile_tb.sv
/*
 * testbench for the operand register file: reset sweep, directed table
 * and LFSR-driven random commands checked against a reference model
 */
`timescale 1ns/1ns
`default_nettype none

module regfile_tb;
    import mem_pkg::*;
    import exec_pkg::*;

    localparam int RESET_CYCLES   = 3;
    localparam int TABLE_LEN      = 16;
    localparam int RANDOM_CMDS    = 64;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + DEPTH + TABLE_LEN + RANDOM_CMDS + 50;
    localparam logic [31:0] SEED  = 32'd92203;

    // one directed command with the result it must return
    typedef struct packed {
        logic      valid;
        cmd_t      cmd;
        mem_data_t value;
        mem_data_t old;
    } vec_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        cmd_valid;
    cmd_t        cmd;
    logic        ready;
    logic        res_valid;
    result_t     res;

    vec_t        tbl [TABLE_LEN];
    mem_data_t   ref_mem [DEPTH];
    logic [31:0] lfsr_state = SEED;
    int          sweep_left = DEPTH;
    logic        exp_ready = 1'b0;
    logic        pend_valid = 1'b0;
    mem_data_t   pend_value;
    mem_data_t   pend_old;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count = 0;

    regfile_top uut (
        .clk,
        .rst,
        .cmd_valid,
        .cmd,
        .ready,
        .res_valid,
        .res
    );

    always #50 clk = ~clk;

    function automatic cmd_t command(opcode_t op, int dst, int a, int b, int imm);
        cmd_t c;
        c.op    = op;
        c.dst   = mem_addr_t'(dst);
        c.src_a = mem_addr_t'(a);
        c.src_b = mem_addr_t'(b);
        c.imm   = mem_data_t'(imm);
        return c;
    endfunction

    function automatic vec_t entry(logic valid, cmd_t c, int value, int old);
        vec_t v;
        v.valid = valid;
        v.cmd   = c;
        v.value = mem_data_t'(value);
        v.old   = mem_data_t'(old);
        return v;
    endfunction

    // galois form, taps for x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [15:0] take_bits(int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            bits = {bits[14:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // expected result from the register file rules, S is ref_mem before the write
    function automatic void model_expect(cmd_t c, output mem_data_t value, output mem_data_t old);
        old = ref_mem[c.dst];
        case (c.op)
            OP_LOAD: value = c.imm;
            OP_ADD:  value = ref_mem[c.src_a] + ref_mem[c.src_b];
            OP_SUB:  value = ref_mem[c.src_a] - ref_mem[c.src_b];
            OP_READ: value = ref_mem[c.src_a];
            default: value = '0;
        endcase
    endfunction

    task automatic fill_table();
        tbl[0]  = entry(1'b1, command(OP_LOAD, 1, 0, 0, 'h1234), 'h1234, 'h0000);
        tbl[1]  = entry(1'b1, command(OP_READ, 1, 1, 0, 0), 'h1234, 'h1234);
        tbl[2]  = entry(1'b1, command(OP_LOAD, 1, 0, 0, 'habcd), 'habcd, 'h1234);
        tbl[3]  = entry(1'b1, command(OP_READ, 2, 1, 0, 0), 'habcd, 'h0000);
        tbl[4]  = entry(1'b1, command(OP_LOAD, 2, 0, 0, 'hfff0), 'hfff0, 'h0000);
        tbl[5]  = entry(1'b1, command(OP_ADD, 3, 1, 2, 0), 'habbd, 'h0000);
        tbl[6]  = entry(1'b1, command(OP_ADD, 3, 3, 2, 0), 'habad, 'habbd);
        tbl[7]  = entry(1'b1, command(OP_SUB, 4, 2, 1, 0), 'h5423, 'h0000);
        tbl[8]  = entry(1'b1, command(OP_SUB, 5, 1, 3, 0), 'h0020, 'h0000);
        tbl[9]  = entry(1'b1, command(OP_SUB, 5, 5, 2, 0), 'h0030, 'h0020);
        tbl[10] = entry(1'b1, command(OP_NOP, 5, 0, 0, 'h7777), 0, 0);
        tbl[11] = entry(1'b0, command(OP_LOAD, 6, 0, 0, 'hffff), 0, 0);
        tbl[12] = entry(1'b1, command(OP_READ, 5, 5, 0, 0), 'h0030, 'h0030);
        tbl[13] = entry(1'b1, command(OP_READ, 6, 6, 0, 0), 'h0000, 'h0000);
        tbl[14] = entry(1'b1, command(OP_ADD, 0, 4, 4, 0), 'ha846, 'h0000);
        tbl[15] = entry(1'b1, command(OP_NOP, 0, 0, 0, 0), 0, 0);
    endtask

    task automatic check_outputs();
        assert (ready === exp_ready) else begin
            $display("FAILED ready: got %h expected %h", ready, exp_ready);
            value_errors++;
        end
        assert (res_valid === pend_valid) else begin
            $display("FAILED res_valid: got %h expected %h", res_valid, pend_valid);
            value_errors++;
        end
        if (pend_valid) begin
            assert (res.value === pend_value) else begin
                $display("FAILED res.value: got %h expected %h", res.value, pend_value);
                value_errors++;
            end
            assert (res.old === pend_old) else begin
                $display("FAILED res.old: got %h expected %h", res.old, pend_old);
                value_errors++;
            end
        end
    endtask

    // drive one command, check the result of the previous one at the falling edge
    task automatic step(logic valid, cmd_t c, mem_data_t exp_value, mem_data_t exp_old);
        logic accepted;
        @(posedge clk);
        cmd_valid <= valid;
        cmd       <= c;
        if (sweep_left > 0) begin
            sweep_left--;
        end
        @(negedge clk);
        exp_ready = (sweep_left == 0);
        check_outputs();
        accepted   = valid && exp_ready;
        pend_valid = accepted && (c.op inside {OP_LOAD, OP_ADD, OP_SUB, OP_READ});
        pend_value = exp_value;
        pend_old   = exp_old;
        if (accepted && (c.op inside {OP_LOAD, OP_ADD, OP_SUB})) begin
            ref_mem[c.dst] = exp_value;
        end
    endtask

    task automatic report_counts();
        $display("error counts: %0d value, %0d other, %0d property",
                 value_errors, other_errors, uut.props_inst.failures);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the command sequence did not complete",
                     cycle_count);
            other_errors++;
            report_counts();
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        cmd_t      c;
        logic      valid;
        mem_data_t value;
        mem_data_t old;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        fill_table();
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // sweep window, a load here must be dropped
        repeat (DEPTH - 1) begin
            step(1'b1, command(OP_LOAD, 5, 0, 0, 'hffff), '0, '0);
        end
        for (int a = 0; a < DEPTH; a++) begin
            step(1'b1, command(OP_READ, a, a, 0, 0), '0, '0);
        end
        for (int i = 0; i < TABLE_LEN; i++) begin
            step(tbl[i].valid, tbl[i].cmd, tbl[i].value, tbl[i].old);
        end

        // low addresses only, so commands hit each other often
        repeat (RANDOM_CMDS) begin
            valid   = (take_bits(2) != 0);
            c.op    = opcode_t'(3'(take_bits(3) % 5));
            c.dst   = mem_addr_t'(take_bits(3));
            c.src_a = mem_addr_t'(take_bits(3));
            c.src_b = mem_addr_t'(take_bits(3));
            c.imm   = take_bits(16);
            model_expect(c, value, old);
            step(valid, c, value, old);
        end
        step(1'b0, '0, '0, '0);

        report_counts();
        if (value_errors + other_errors + uut.props_inst.failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- regfile_properties.sv
/*
 * concurrent checks on the top-level strobes, bound to regfile_top
 */
`timescale 1ns/1ns
`default_nettype none

module regfile_properties (
    input wire                 clk,
    input wire                 rst,
    input wire                 cmd_valid,
    input wire exec_pkg::cmd_t cmd,
    input wire                 ready,
    input wire                 res_valid
);
    import exec_pkg::*;

    int unsigned failures = 0;
    logic        accept_op;

    // accepted commands that return a result
    assign accept_op = cmd_valid && ready && (cmd.op inside {OP_LOAD, OP_ADD, OP_SUB, OP_READ});

    res_needs_ready: assert property (@(posedge clk) disable iff (rst) res_valid |-> ready)
        else begin
            $error("res_valid high while ready is low");
            failures++;
        end

    // once the sweep is over only reset takes ready away
    ready_holds: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
        else begin
            $error("ready fell without reset");
            failures++;
        end

    res_after_accept: assert property (@(posedge clk) disable iff (rst) accept_op |=> res_valid)
        else begin
            $error("no res_valid one cycle after an accepted command");
            failures++;
        end

    no_spurious_res: assert property (@(posedge clk) disable iff (rst) !accept_op |=> !res_valid)
        else begin
            $error("res_valid without an accepted command");
            failures++;
        end

endmodule

bind regfile_top regfile_properties props_inst (
    .clk,
    .rst,
    .cmd_valid,
    .cmd,
    .ready,
    .res_valid
);

`default_nettype wire

//--- regfile_top.sv
/*
 * operand register file top level
 * execute block in front of the auto-clearing memory
 */
`timescale 1ns/1ns
`default_nettype none

module regfile_top (
    input  wire                    clk,
    input  wire                    rst,

    input  wire                    cmd_valid,
    input  wire exec_pkg::cmd_t    cmd,
    output logic                   ready,

    output logic                   res_valid,
    output exec_pkg::result_t      res
);
    import mem_pkg::*;

    mem_write_t                  wr;
    mem_addr_t [READ_PORTS-1:0]  read_addr;
    mem_data_t [READ_PORTS-1:0]  read_data_out;
    mem_data_t                   write_data_out;
    logic                        reset_done;

    // commands are taken only once the sweep has finished
    assign ready = reset_done;

    regfile_exec exec_inst (
        .clk,
        .rst,
        .cmd_valid,
        .cmd,
        .reset_done,
        .wr,
        .read_addr,
        .read_data_out,
        .write_data_out,
        .res_valid,
        .res
    );

    mem_combinational #(
        .AUTO_RESET(1)
    ) mem_inst (
        .clk,
        .rst,
        .wr,
        .write_data_out,
        .read_addr,
        .read_data_out,
        .reset_done
    );

endmodule

`default_nettype wire

//--- regfile_exec.sv
/*
 * command decode, operand fetch and load/add/sub/read execution
 * write-back to the register file and a registered result
 */
`timescale 1ns/1ns
`default_nettype none

module regfile_exec (
    input  wire                                                clk,
    input  wire                                                rst,

    input  wire                                                cmd_valid,
    input  wire exec_pkg::cmd_t                                cmd,
    input  wire                                                reset_done,

    output mem_pkg::mem_write_t                                wr,
    output mem_pkg::mem_addr_t [mem_pkg::READ_PORTS-1:0]       read_addr,
    input  wire mem_pkg::mem_data_t [mem_pkg::READ_PORTS-1:0]  read_data_out,
    input  wire mem_pkg::mem_data_t                            write_data_out,

    output logic                                               res_valid,
    output exec_pkg::result_t                                  res
);
    import mem_pkg::*;
    import exec_pkg::*;

    logic      accept;
    logic      do_write;
    logic      do_result;
    mem_data_t value;

    // commands outside the sweep only, anything else is dropped
    assign accept = cmd_valid && reset_done;

    // operands are fetched in the same cycle as the command
    assign read_addr[0] = cmd.src_a;
    assign read_addr[1] = cmd.src_b;

    always_comb begin
        do_write  = 1'b0;
        do_result = 1'b0;
        value     = '0;
        case (cmd.op)
            OP_LOAD: begin
                do_write  = 1'b1;
                do_result = 1'b1;
                value     = cmd.imm;
            end
            OP_ADD: begin
                do_write  = 1'b1;
                do_result = 1'b1;
                value     = read_data_out[0] + read_data_out[1];
            end
            OP_SUB: begin
                do_write  = 1'b1;
                do_result = 1'b1;
                value     = read_data_out[0] - read_data_out[1];
            end
            OP_READ: begin
                do_result = 1'b1;
                value     = read_data_out[0];
            end
            // nop and unused encodings do nothing
            default: begin
                do_write  = 1'b0;
                do_result = 1'b0;
            end
        endcase
    end

    // dst is always addressed so write_data_out returns the old contents
    always_comb begin
        wr.enable = accept && do_write;
        wr.addr   = cmd.dst;
        wr.data   = value;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= accept && do_result;
        end
    end

    always_ff @(posedge clk) begin
        res.value <= value;
        res.old   <= write_data_out;
    end

endmodule

`default_nettype wire

//--- mem_combinational.sv
/*
 * memory with one write port and same-cycle read ports
 * optional clearing sweep after reset, reported through reset_done
 */
`timescale 1ns/1ns
`default_nettype none

module mem_combinational #(
    parameter int AUTO_RESET = 0
)(
    input  wire                                                clk,
    input  wire                                                rst,

    input  wire mem_pkg::mem_write_t                           wr,
    output mem_pkg::mem_data_t                                 write_data_out,

    input  wire mem_pkg::mem_addr_t [mem_pkg::READ_PORTS-1:0]  read_addr,
    output mem_pkg::mem_data_t [mem_pkg::READ_PORTS-1:0]       read_data_out,

    output logic                                               reset_done
);
    import mem_pkg::*;

    // write port after the sweep multiplexer
    mem_write_t ram_wr;

    mem_reset_sequencer #(
        .AUTO_RESET(AUTO_RESET)
    ) reset_sequencer_inst (
        .clk,
        .rst,
        .wr,
        .ram_wr,
        .reset_done
    );

    mem_distributed_ram distributed_ram_inst (
        .clk,
        .ram_wr,
        .read_addr,
        .read_data_out,
        .write_data_out
    );

endmodule

`default_nettype wire

//--- mem_distributed_ram.sv
/*
 * flop-array RAM with combinational multi-port reads
 * plus an asynchronous read of the current write address
 */
`timescale 1ns/1ns
`default_nettype none

module mem_distributed_ram (
    input  wire                                                clk,
    input  wire mem_pkg::mem_write_t                           ram_wr,
    input  wire mem_pkg::mem_addr_t [mem_pkg::READ_PORTS-1:0]  read_addr,
    output mem_pkg::mem_data_t [mem_pkg::READ_PORTS-1:0]       read_data_out,
    output mem_pkg::mem_data_t                                 write_data_out
);
    import mem_pkg::*;

    mem_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (ram_wr.enable) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // every port sees the contents before this edge's write
    always_comb begin
        for (int i = 0; i < READ_PORTS; i++) begin
            read_data_out[i] = mem[read_addr[i]];
        end
        write_data_out = mem[ram_wr.addr];
    end

endmodule

`default_nettype wire

//--- mem_reset_sequencer.sv
/*
 * post-reset clearing sweep over every memory address
 * and the write-port multiplexer in front of the RAM
 */
`timescale 1ns/1ns
`default_nettype none

module mem_reset_sequencer #(
    parameter int AUTO_RESET = 0
)(
    input  wire                      clk,
    input  wire                      rst,
    input  wire mem_pkg::mem_write_t wr,
    output mem_pkg::mem_write_t      ram_wr,
    output logic                     reset_done
);
    import mem_pkg::*;

    generate
        if (AUTO_RESET != 0) begin : g_sweep
            logic      sweep_active;
            mem_addr_t sweep_addr;

            // flag is armed by reset and drops after the last address
            always_ff @(posedge clk) begin
                if (rst) begin
                    sweep_active <= 1'b1;
                    sweep_addr   <= '0;
                end else if (sweep_active) begin
                    sweep_addr <= sweep_addr + 1'b1;
                    if (sweep_addr == mem_addr_t'(DEPTH - 1)) begin
                        sweep_active <= 1'b0;
                    end
                end
            end

            always_comb begin
                reset_done = !sweep_active;
                if (sweep_active) begin
                    // zero one word per cycle, user writes are ignored
                    ram_wr.enable = 1'b1;
                    ram_wr.addr   = sweep_addr;
                    ram_wr.data   = '0;
                end else begin
                    ram_wr = wr;
                end
            end
        end else begin : g_pass
            // contents stay undefined until written
            always_comb begin
                reset_done = 1'b1;
                ram_wr     = wr;
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- exec_pkg.sv
/*
 * opcode encoding for the execute block
 * command and result records exchanged at the top level
 */
`default_nettype none

package exec_pkg;

    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_LOAD = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_READ = 3'd4
    } opcode_t;

    // one command per cycle, qualified by cmd_valid
    typedef struct packed {
        opcode_t           op;
        mem_pkg::mem_addr_t dst;
        mem_pkg::mem_addr_t src_a;
        mem_pkg::mem_addr_t src_b;
        mem_pkg::mem_data_t imm;
    } cmd_t;

    // old holds the contents of dst before the command
    typedef struct packed {
        mem_pkg::mem_data_t value;
        mem_pkg::mem_data_t old;
    } result_t;

endpackage

`default_nettype wire

//--- mem_pkg.sv
/*
 * memory geometry for the operand register file
 * address, data and write-port types shared by the memory blocks
 */
`default_nettype none

package mem_pkg;

    // 32 entries of 16 bits
    localparam int DATA_WIDTH = 16;
    localparam int ADDR_WIDTH = 5;
    localparam int DEPTH      = 1 << ADDR_WIDTH;

    // one port per operand
    localparam int READ_PORTS = 2;

    typedef logic [ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [DATA_WIDTH-1:0] mem_data_t;

    // single write port, one enable for the whole word
    typedef struct packed {
        logic      enable;
        mem_addr_t addr;
        mem_data_t data;
    } mem_write_t;

endpackage

`default_nettype wire
